// File: Makefile
# Verilator build for the fetch front end testbench

VERILATOR ?= verilator
TOP       ?= tb_fetch_frontend
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# the simulator exits non-zero on $$fatal, so make fails with it
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// File: src.f
+incdir+src
src/fetch_pkg.sv
src/inst_predecoder.sv
src/predecode_stage.sv
src/inst_queue.sv
src/fetch_frontend.sv
verification/predecode_props.sv
verification/tb_fetch_frontend.sv

// File: src/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// instruction slots in one aligned fetch block
`define BLOCK_INSTS 8

// bits needed to name one slot
`define SLOT_IDX_W 3

// virtual address width
`define VADDR_W 32

// fetch target queue index width
`define FSQ_IDX_W 4

// instruction buffer entries, power of two
`define IBUF_DEPTH 16

`endif

// File: src/fetch_frontend.sv
`include "fetch_defines.svh"

module fetch_frontend import fetch_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  fetch_block_t blk_in,
    input  logic         blk_valid,
    output logic         blk_ready,
    output ibuf_entry_t  deq,
    output logic         deq_valid,
    input  logic         deq_ready,
    output redirect_t    redirect
);

    ibuf_write_t wr;
    logic        wr_valid;
    logic        wr_ready;

    predecode_stage pd_stage_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .blk_in    (blk_in),
        .blk_valid (blk_valid),
        .blk_ready (blk_ready),
        .wr        (wr),
        .wr_valid  (wr_valid),
        .wr_ready  (wr_ready),
        .redirect  (redirect)
    );

    // decode stage outside pulls from the queue
    inst_queue inst_queue_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr        (wr),
        .wr_valid  (wr_valid),
        .wr_ready  (wr_ready),
        .deq       (deq),
        .deq_valid (deq_valid),
        .deq_ready (deq_ready)
    );

endmodule

// File: src/fetch_pkg.sv
`include "fetch_defines.svh"

package fetch_pkg;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // same 32-bit word seen as J-type or I-type
    typedef union packed {
        j_fmt_t j_fmt;
        i_fmt_t i_fmt;
    } rv_inst_u;

    typedef enum logic [2:0] {
        br_none,
        br_jal_direct,
        br_call,
        br_ret_indirect,
        br_indirect,
        br_conditional
    } br_type_e;

    typedef enum logic [1:0] {
        ras_none,
        ras_push,
        ras_pop,
        ras_pop_push
    } ras_type_e;

    typedef struct packed {
        br_type_e              br_type;
        ras_type_e             ras_type;
        logic                  is_jal;
        logic [`VADDR_W-1:0]   jal_target;
    } predecode_t;

    typedef struct packed {
        rv_inst_u [`BLOCK_INSTS-1:0] insts;
        logic [`BLOCK_INSTS-1:0]     slot_valid;
        logic [`VADDR_W-1:0]         start_pc;
        logic [`FSQ_IDX_W-1:0]       fsq_idx;
        logic                        pred_taken;
        logic [`SLOT_IDX_W-1:0]      pred_slot;
        logic [`VADDR_W-1:0]         pred_target;
    } fetch_block_t;

    typedef struct packed {
        logic                   valid;
        logic [`FSQ_IDX_W-1:0]  fsq_idx;
        logic [`SLOT_IDX_W-1:0] slot;
        br_type_e               br_type;
        ras_type_e              ras_type;
        logic [`VADDR_W-1:0]    pc;       // start pc of the block
        logic [`VADDR_W-1:0]    target;
    } redirect_t;

    typedef struct packed {
        rv_inst_u [`BLOCK_INSTS-1:0] insts;
        logic [`BLOCK_INSTS-1:0]     slot_valid;
        logic [`SLOT_IDX_W:0]        count;
        logic [`VADDR_W-1:0]         start_pc;
        logic [`FSQ_IDX_W-1:0]       fsq_idx;
    } ibuf_write_t;

    typedef struct packed {
        rv_inst_u              inst;
        logic [`VADDR_W-1:0]   pc;
        logic [`FSQ_IDX_W-1:0] fsq_idx;
    } ibuf_entry_t;

endpackage

// File: src/inst_predecoder.sv
`include "fetch_defines.svh"

module inst_predecoder import fetch_pkg::*; (
    input  rv_inst_u            inst,
    input  logic [`VADDR_W-1:0] pc,
    output predecode_t          pd
);

    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    logic                is_jal;
    logic                is_jalr;
    logic                is_branch;
    logic                rd_link;
    logic                rs1_link;
    logic [`VADDR_W-1:0] j_imm;

    assign is_jal    = inst.j_fmt.opcode == OP_JAL;
    assign is_jalr   = inst.i_fmt.opcode == OP_JALR;
    assign is_branch = inst.i_fmt.opcode == OP_BRANCH;

    // x1 and x5 are the link registers
    assign rd_link  = (inst.i_fmt.rd == 5'd1) || (inst.i_fmt.rd == 5'd5);
    assign rs1_link = (inst.i_fmt.rs1 == 5'd1) || (inst.i_fmt.rs1 == 5'd5);

    assign j_imm = {{(`VADDR_W-20){inst.j_fmt.imm20}}, inst.j_fmt.imm19_12,
                    inst.j_fmt.imm11, inst.j_fmt.imm10_1, 1'b0};

    always_comb begin
        pd.is_jal     = is_jal;
        pd.jal_target = pc + j_imm;
        pd.br_type    = br_none;
        pd.ras_type   = ras_none;
        if (is_jal) begin
            pd.br_type = br_jal_direct;
            if (rd_link) begin
                pd.ras_type = ras_push;  // direct call
            end
        end else if (is_jalr) begin
            case ({rd_link, rs1_link})
                2'b10: begin
                    pd.br_type  = br_call;
                    pd.ras_type = ras_push;
                end
                2'b01: begin
                    pd.br_type  = br_ret_indirect;
                    pd.ras_type = ras_pop;
                end
                2'b11: begin
                    pd.br_type  = br_call;
                    pd.ras_type = ras_pop_push;  // coroutine style swap
                end
                default: pd.br_type = br_indirect;
            endcase
        end else if (is_branch) begin
            pd.br_type = br_conditional;
        end
    end

endmodule

// File: src/inst_queue.sv
`include "fetch_defines.svh"

module inst_queue import fetch_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  ibuf_write_t wr,
    input  logic        wr_valid,
    output logic        wr_ready,
    output ibuf_entry_t deq,
    output logic        deq_valid,
    input  logic        deq_ready
);

    localparam int PTR_W = $clog2(`IBUF_DEPTH);

    ibuf_entry_t      mem [`IBUF_DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W:0]   occ;
    logic [PTR_W:0]   free_cnt;
    logic [PTR_W:0]   wr_add;
    logic             wr_fire;
    logic             deq_fire;
    logic [PTR_W-1:0] wr_ofs;
    logic [PTR_W-1:0] wr_idx [`BLOCK_INSTS];

    assign free_cnt = (PTR_W+1)'(`IBUF_DEPTH) - occ;
    assign wr_ready = free_cnt >= (PTR_W+1)'(wr.count);  // whole block or nothing
    assign wr_fire  = wr_valid && wr_ready;
    assign deq_valid = occ != '0;
    assign deq_fire = deq_valid && deq_ready;
    assign deq      = mem[head];
    assign wr_add   = wr_fire ? (PTR_W+1)'(wr.count) : '0;

    // pack valid slots into consecutive entries from tail
    always_comb begin
        wr_ofs = '0;
        for (int i = 0; i < `BLOCK_INSTS; i++) begin
            wr_idx[i] = tail + wr_ofs;
            wr_ofs    = wr_ofs + PTR_W'(wr.slot_valid[i]);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `BLOCK_INSTS; i++) begin
            if (wr_fire && wr.slot_valid[i]) begin
                mem[wr_idx[i]] <= '{inst:    wr.insts[i],
                                    pc:      wr.start_pc + `VADDR_W'(i * 4),
                                    fsq_idx: wr.fsq_idx};
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head <= '0;
            tail <= '0;
            occ  <= '0;
        end else begin
            if (wr_fire) begin
                tail <= tail + PTR_W'(wr.count);
            end
            if (deq_fire) begin
                head <= head + 1'b1;
            end
            occ <= occ + wr_add - (PTR_W+1)'(deq_fire);
        end
    end

endmodule

// File: src/predecode_stage.sv
`include "fetch_defines.svh"

module predecode_stage import fetch_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  fetch_block_t blk_in,
    input  logic         blk_valid,
    output logic         blk_ready,
    output ibuf_write_t  wr,
    output logic         wr_valid,
    input  logic         wr_ready,
    output redirect_t    redirect
);

    fetch_block_t           held_blk;
    logic                   held_valid;
    predecode_t             pd [`BLOCK_INSTS];
    logic [`BLOCK_INSTS-1:0] jal_vec;
    logic                   jal_found;
    logic [`SLOT_IDX_W-1:0] jal_slot;
    predecode_t             jal_pd;
    logic                   redir_hit;
    logic                   leave;
    logic [`BLOCK_INSTS-1:0] keep_mask;
    logic [`BLOCK_INSTS-1:0] wr_mask;
    logic [`SLOT_IDX_W:0]   wr_cnt;

    assign leave     = held_valid && wr_ready;
    assign blk_ready = !held_valid || wr_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_valid <= 1'b0;
        end else if (blk_valid && blk_ready) begin
            held_valid <= 1'b1;
        end else if (leave) begin
            held_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (blk_valid && blk_ready) begin
            held_blk <= blk_in;
        end
    end

    for (genvar i = 0; i < `BLOCK_INSTS; i++) begin : g_pd
        inst_predecoder inst_predecoder_i (
            .inst (held_blk.insts[i]),
            .pc   (held_blk.start_pc + `VADDR_W'(i * 4)),
            .pd   (pd[i])
        );
        assign jal_vec[i] = held_blk.slot_valid[i] && pd[i].is_jal;
    end

    // lowest valid jal wins
    always_comb begin
        jal_found = 1'b0;
        jal_slot  = '0;
        for (int i = `BLOCK_INSTS - 1; i >= 0; i--) begin
            if (jal_vec[i]) begin
                jal_found = 1'b1;
                jal_slot  = `SLOT_IDX_W'(i);
            end
        end
    end

    assign jal_pd = pd[jal_slot];

    always_comb begin
        if (held_blk.pred_taken) begin
            redir_hit = !jal_found || (jal_slot != held_blk.pred_slot) ||
                        (jal_pd.jal_target != held_blk.pred_target);
        end else begin
            redir_hit = jal_found;
        end
    end

    // control leaves the block at the first jal, so later slots are dropped
    always_comb begin
        for (int i = 0; i < `BLOCK_INSTS; i++) begin
            keep_mask[i] = !jal_found || (i <= int'(jal_slot));
        end
    end

    assign wr_mask = held_blk.slot_valid & keep_mask;

    always_comb begin
        wr_cnt = '0;
        for (int i = 0; i < `BLOCK_INSTS; i++) begin
            wr_cnt = wr_cnt + (`SLOT_IDX_W+1)'(wr_mask[i]);
        end
    end

    assign wr_valid      = held_valid;
    assign wr.insts      = held_blk.insts;
    assign wr.slot_valid = wr_mask;
    assign wr.count      = wr_cnt;
    assign wr.start_pc   = held_blk.start_pc;
    assign wr.fsq_idx    = held_blk.fsq_idx;

    assign redirect.valid    = leave && redir_hit;  // only on the write handshake
    assign redirect.fsq_idx  = held_blk.fsq_idx;
    assign redirect.slot     = jal_found ? jal_slot : held_blk.pred_slot;
    assign redirect.br_type  = jal_found ? jal_pd.br_type : br_none;
    assign redirect.ras_type = jal_found ? jal_pd.ras_type : ras_none;
    assign redirect.pc       = held_blk.start_pc;
    // false taken goes back to the fall-through block
    assign redirect.target   = jal_found ? jal_pd.jal_target :
                               held_blk.start_pc + `VADDR_W'(`BLOCK_INSTS * 4);

endmodule

// File: verification/predecode_props.sv
`include "fetch_defines.svh"

module predecode_props import fetch_pkg::*; (
    input logic        clk,
    input logic        rst_n,
    input ibuf_write_t wr,
    input logic        wr_valid,
    input logic        wr_ready,
    input redirect_t   redirect
);
    timeunit 1ns;
    timeprecision 100ps;

    wr_held: assert property (@(posedge clk) disable iff (!rst_n)
        wr_valid && !wr_ready |=> wr_valid && $stable(wr))
        else $error("buffer write changed while stalled");

    // a jal redirect cuts the write right after its own slot
    redirect_on_write: assert property (@(posedge clk) disable iff (!rst_n)
        redirect.valid |-> wr_valid && wr_ready &&
        (redirect.br_type == br_none ||
         (wr.slot_valid >> redirect.slot) == `BLOCK_INSTS'(1)))
        else $error("redirect raised without a buffer write ending at its slot");

    // mask must be a prefix so the queue can pack it in order
    count_matches_mask: assert property (@(posedge clk) disable iff (!rst_n)
        wr_valid |-> int'(wr.count) == $countones(wr.slot_valid) &&
        ((wr.slot_valid + `BLOCK_INSTS'(1)) & wr.slot_valid) == '0)
        else $error("write count or mask shape is wrong");

    idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !wr_valid)
        else $error("write valid high right after reset");

endmodule

bind predecode_stage predecode_props props_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr       (wr),
    .wr_valid (wr_valid),
    .wr_ready (wr_ready),
    .redirect (redirect)
);

// File: verification/tb_fetch_frontend.sv
`include "fetch_defines.svh"

module tb_fetch_frontend import fetch_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          NUM_BLOCKS = 400;
    localparam int          WAIT_LIMIT = 2000;
    localparam logic [31:0] SEED       = 32'd38962;
    localparam logic [6:0]  OPC_JAL    = 7'b1101111;

    logic         clk;
    logic         rst_n;
    fetch_block_t blk_in;
    logic         blk_valid;
    logic         blk_ready;
    ibuf_entry_t  deq;
    logic         deq_valid;
    logic         deq_ready;
    redirect_t    redirect;

    ibuf_entry_t exp_entries[$];
    redirect_t   exp_redirects[$];
    logic [31:0] stim_state;
    int          entry_cnt = 0;

    fetch_frontend dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .blk_in    (blk_in),
        .blk_valid (blk_valid),
        .blk_ready (blk_ready),
        .deq       (deq),
        .deq_valid (deq_valid),
        .deq_ready (deq_ready),
        .redirect  (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        stim_state = xorshift32(stim_state);
        return stim_state;
    endfunction

    function automatic logic [4:0] pick_reg(logic [31:0] r);
        case (r[1:0])
            2'd0: return 5'd1;
            2'd1: return 5'd5;
            2'd2: return 5'd0;
            default: return r[6:2];
        endcase
    endfunction

    // slot of the first valid jal or -1 and its target from the J immediate
    function automatic int first_jal(fetch_block_t b, output logic [31:0] target);
        logic [31:0] w;
        logic [31:0] pc;
        target = '0;
        for (int i = 0; i < `BLOCK_INSTS; i++) begin
            w = b.insts[i];
            if (b.slot_valid[i] && w[6:0] == OPC_JAL) begin
                pc = b.start_pc + 32'(4 * i);
                target = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                return i;
            end
        end
        return -1;
    endfunction

    task automatic abort_run(string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_entry(string name, ibuf_entry_t exp, ibuf_entry_t act);
        if (act !== exp) begin
            abort_run($sformatf({"MISMATCH %s expected inst=%h pc=%h fsq=%h",
                " actual inst=%h pc=%h fsq=%h"}, name,
                exp.inst, exp.pc, exp.fsq_idx, act.inst, act.pc, act.fsq_idx));
        end
    endtask

    task automatic check_redirect(string name, redirect_t exp, redirect_t act);
        if (act !== exp) begin
            abort_run($sformatf({"MISMATCH %s expected fsq=%h slot=%0d %s %s pc=%h target=%h",
                " actual v=%b fsq=%h slot=%0d %s %s pc=%h target=%h"}, name,
                exp.fsq_idx, exp.slot, exp.br_type.name(), exp.ras_type.name(), exp.pc,
                exp.target, act.valid, act.fsq_idx, act.slot, act.br_type.name(),
                act.ras_type.name(), act.pc, act.target));
        end
    endtask

    task automatic make_block(int n, output fetch_block_t b);
        logic [31:0] r;
        logic [31:0] w;
        logic [31:0] tgt;
        int          slot;
        b = '0;
        for (int i = 0; i < `BLOCK_INSTS; i++) begin
            r = next_rand();
            w = next_rand();
            case (r[2:0])
                3'd0: w[6:0] = OPC_JAL;
                3'd1, 3'd2: begin
                    w[6:0]   = 7'b1100111;  // jalr
                    w[19:15] = pick_reg(r >> 3);
                end
                3'd3: w[6:0] = 7'b1100011;
                default: w[6:0] = 7'b0010011;
            endcase
            if (r[2:0] <= 3'd2) begin
                w[11:7] = pick_reg(r >> 8);
            end
            b.insts[i] = w;
        end
        r = next_rand();
        b.slot_valid = `BLOCK_INSTS'((1 << (1 + int'(r[2:0]))) - 1);
        b.start_pc   = {r[31:5], 5'b0};
        b.fsq_idx    = `FSQ_IDX_W'(n);
        slot = first_jal(b, tgt);
        r = next_rand();
        case (r[1:0])
            2'd0: b.pred_taken = 1'b0;
            2'd1: begin  // right guess
                b.pred_taken  = slot >= 0;
                b.pred_slot   = `SLOT_IDX_W'(slot);
                b.pred_target = tgt;
            end
            2'd2: begin
                b.pred_taken  = 1'b1;
                b.pred_slot   = r[4:2];
                b.pred_target = tgt;
            end
            default: begin
                b.pred_taken  = 1'b1;
                b.pred_slot   = `SLOT_IDX_W'(slot);
                b.pred_target = tgt ^ {r[31:2], 2'b0};
            end
        endcase
    endtask

    task automatic model_block(fetch_block_t b);
        int          slot;
        logic [31:0] tgt;
        logic [31:0] w;
        logic        redir;
        ibuf_entry_t e;
        redirect_t   r;
        slot = first_jal(b, tgt);
        for (int i = 0; i < `BLOCK_INSTS; i++) begin
            if (b.slot_valid[i] && (slot < 0 || i <= slot)) begin
                e.inst    = b.insts[i];
                e.pc      = b.start_pc + 32'(4 * i);
                e.fsq_idx = b.fsq_idx;
                exp_entries.push_back(e);
            end
        end
        if (slot < 0) begin
            redir = b.pred_taken;
        end else begin
            redir = !b.pred_taken || int'(b.pred_slot) != slot || b.pred_target != tgt;
        end
        if (redir) begin
            r.valid   = 1'b1;
            r.fsq_idx = b.fsq_idx;
            r.pc      = b.start_pc;
            if (slot < 0) begin
                r.slot     = b.pred_slot;
                r.br_type  = br_none;
                r.ras_type = ras_none;
                r.target   = b.start_pc + 32'd32;  // fall-through block
            end else begin
                w          = b.insts[slot];
                r.slot     = `SLOT_IDX_W'(slot);
                r.br_type  = br_jal_direct;
                r.ras_type = ras_none;
                if (w[11:7] == 5'd1 || w[11:7] == 5'd5) begin
                    r.ras_type = ras_push;
                end
                r.target   = tgt;
            end
            exp_redirects.push_back(r);
        end
    endtask

    // decode side with long random stalls
    initial begin
        logic [31:0] rdy_state;
        int          pause;
        deq_ready = 1'b0;
        rdy_state = ~SEED;
        pause     = 0;
        forever begin
            @(posedge clk);
            if (!rst_n) begin
                deq_ready <= 1'b0;
            end else if (pause > 0) begin
                pause = pause - 1;
                deq_ready <= 1'b0;
            end else begin
                rdy_state = xorshift32(rdy_state);
                if (rdy_state[5:0] == 6'd0) begin
                    pause = 24 + int'(rdy_state[10:6]);
                end
                deq_ready <= rdy_state[12:11] != 2'd0;
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n && deq_valid && deq_ready) begin
            if (exp_entries.size() == 0) begin
                abort_run("an entry left the queue that no accepted block produced");
            end else begin
                check_entry($sformatf("entry %0d", entry_cnt), exp_entries.pop_front(), deq);
                entry_cnt++;
            end
        end
        if (rst_n && redirect.valid) begin
            if (exp_redirects.size() == 0) begin
                abort_run("a redirect was raised for a block that should not redirect");
            end else begin
                check_redirect($sformatf("redirect fsq %0d", redirect.fsq_idx),
                    exp_redirects.pop_front(), redirect);
            end
        end
    end

    initial begin
        fetch_block_t blk;
        logic [31:0]  r;
        int           gap;
        int           waited;
        stim_state = SEED;
        rst_n      = 1'b0;
        blk_valid  = 1'b0;
        blk_in     = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        if (blk_ready !== 1'b1 || deq_valid !== 1'b0 || redirect.valid !== 1'b0) begin
            abort_run("front end outputs were not idle after reset");
        end
        for (int n = 0; n < NUM_BLOCKS; n++) begin
            make_block(n, blk);
            r = next_rand();
            gap = r[3] ? int'(r[1:0]) : 0;
            for (int g = 0; g < gap; g++) begin
                blk_valid <= 1'b0;
                @(posedge clk);
            end
            blk_in    <= blk;
            blk_valid <= 1'b1;
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
                if (waited > WAIT_LIMIT) begin
                    abort_run($sformatf("block %0d was never accepted by the front end", n));
                end
            end while (!blk_ready);
            model_block(blk);
        end
        blk_valid <= 1'b0;
        waited = 0;
        while (exp_entries.size() != 0 || exp_redirects.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("expected entries or redirects never came out of the front end");
            end
        end
        @(posedge clk);
        if (deq_valid !== 1'b0) begin
            abort_run("the queue still holds entries after all expected ones came out");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule
